// ==== common/fp32_rnd_pkg.sv ====
// shared widths, format constants and bus structs for the fp32 rounding unit and its testbench
package fp32_rnd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and format constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned EXP_W   = 10; // internal exponent, headroom for overflow
  localparam int unsigned FRACT_W = 28; // fraction from exec units, {carry,hidden,f,r,s}
  localparam int unsigned MANT_W  = 25; // aligned mantissa, carry + hidden + 23
  localparam int unsigned SHIFT_W = 5;
  localparam int unsigned NFLAGS  = 8;

  localparam int unsigned EXP_MAX_NORMAL = 254; // biased, anything above overflows

  // magnitudes only, sign is prepended by the round stage
  localparam logic [30:0] FP32_INF  = 31'h7F80_0000;
  localparam logic [30:0] FP32_QNAN = 31'h7FC0_0000;
  localparam logic [30:0] FP32_SNAN = 31'h7FBF_FFFF; // invalid-operation pattern

  typedef logic [EXP_W-1:0]   exp10_t;
  typedef logic [FRACT_W-1:0] fract28_t;
  typedef logic [MANT_W-1:0]  mant25_t;
  typedef logic [SHIFT_W-1:0] shamt_t;
  typedef logic [31:0]        fp32_t;

  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,
    RM_TO_ZERO = 2'd1,
    RM_TO_INFP = 2'd2,
    RM_TO_INFM = 2'd3
  } rnd_mode_t;

  ////////////////////////////////////////////////////////////////////////////
  // execution unit outputs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     sign;
    logic     sub_zero; // effective subtract, zero result
    shamt_t   shl;      // normalizing left shift
    exp10_t   exp_shl;  // exponent if left shifted
    exp10_t   exp_sh0;  // exponent if not shifted
    fract28_t fract;
    logic     inv;
    logic     inf;
    logic     snan;
    logic     qnan;
    logic     nan_sign; // sign for a NaN result
  } add_src_t;

  typedef struct packed {
    logic     sign;
    shamt_t   shr;      // denormalizing right shift
    exp10_t   exp_shr;
    logic     shl;      // mul only ever needs one step left
    exp10_t   exp_shl;
    exp10_t   exp_sh0;
    fract28_t fract;
    logic     inv;
    logic     inf;
    logic     snan;
    logic     qnan;
    logic     nan_sign;
  } mul_src_t;

  ////////////////////////////////////////////////////////////////////////////
  // internal stage and fpcsr flags
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic    sign;
    exp10_t  exp;
    mant25_t mant;    // lsb is the guard bit
    logic    rnd_bit;
    logic    sticky;
    logic    inv;
    logic    inf;
    logic    snan;
    logic    qnan;
    logic    nan_sign;
  } align_stage_t;

  // msb first, matches fpcsr flag field
  typedef struct packed {
    logic inf;
    logic inv;
    logic ine;
    logic zer;
    logic qnan;
    logic snan;
    logic unf;
    logic ovf;
  } fpcsr_flags_t;

endpackage

// ==== hdl/fp32_rnd_align.sv ====
// align stage of the fp32 rounding unit, takes add or mul results and registers the aligned item
`timescale 1ns/1ps

module fp32_rnd_align (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       pipeline_flush_i,
  // exec unit strobes and payloads
  input  logic                       add_rdy_i,
  input  logic                       mul_rdy_i,
  input  fp32_rnd_pkg::add_src_t     add_src_i,
  input  fp32_rnd_pkg::mul_src_t     mul_src_i,
  input  fp32_rnd_pkg::rnd_mode_t    rmode_i,
  input  logic                       wb_take_i,    // padv & grant, item leaves stage
  output logic                       add_taking_o,
  output logic                       mul_taking_o,
  output logic                       valid_o,
  output fp32_rnd_pkg::align_stage_t stage_o
);

  // position of the round bit inside the shifted fraction
  localparam int unsigned RND_POS = fp32_rnd_pkg::FRACT_W - fp32_rnd_pkg::MANT_W - 1;

  ////////////////////////////////////////////////////////////////////////////
  // pipe control
  ////////////////////////////////////////////////////////////////////////////

  logic busy;
  logic adv;

  assign busy = valid_o & ~wb_take_i;            // held item not draining
  assign adv  = (add_rdy_i | mul_rdy_i) & ~busy;

  assign add_taking_o = add_rdy_i & ~busy;
  assign mul_taking_o = mul_rdy_i & ~busy;

  ////////////////////////////////////////////////////////////////////////////
  // source mux
  ////////////////////////////////////////////////////////////////////////////

  fp32_rnd_pkg::fract28_t     sel_fract;
  fp32_rnd_pkg::shamt_t       sel_shr;
  fp32_rnd_pkg::shamt_t       sel_shl;
  fp32_rnd_pkg::exp10_t       sel_exp_shr;
  fp32_rnd_pkg::exp10_t       sel_exp_shl;
  fp32_rnd_pkg::exp10_t       sel_exp_sh0;
  fp32_rnd_pkg::align_stage_t src_d;   // sign and operand class of the chosen source
  fp32_rnd_pkg::align_stage_t stage_d;

  // at most one rdy per cycle, add checked first
  always_comb begin
    src_d = '0;
    if (add_rdy_i) begin
      // zero from effective subtract is -0 only when rounding down
      src_d.sign     = add_src_i.sub_zero ? (rmode_i == fp32_rnd_pkg::RM_TO_INFM)
                                          : add_src_i.sign;
      src_d.inv      = add_src_i.inv;
      src_d.inf      = add_src_i.inf;
      src_d.snan     = add_src_i.snan;
      src_d.qnan     = add_src_i.qnan;
      src_d.nan_sign = add_src_i.nan_sign;
      sel_fract      = add_src_i.fract;
      sel_shr        = '0;                 // add never denormalizes
      sel_shl        = add_src_i.shl;
      sel_exp_shr    = add_src_i.exp_sh0;
      sel_exp_shl    = add_src_i.exp_shl;
      sel_exp_sh0    = add_src_i.exp_sh0;
    end else begin
      src_d.sign     = mul_src_i.sign;
      src_d.inv      = mul_src_i.inv;
      src_d.inf      = mul_src_i.inf;
      src_d.snan     = mul_src_i.snan;
      src_d.qnan     = mul_src_i.qnan;
      src_d.nan_sign = mul_src_i.nan_sign;
      sel_fract      = mul_src_i.fract;
      sel_shr        = mul_src_i.shr;
      sel_shl        = {{(fp32_rnd_pkg::SHIFT_W-1){1'b0}}, mul_src_i.shl};
      sel_exp_shr    = mul_src_i.exp_shr;
      sel_exp_shl    = mul_src_i.exp_shl;
      sel_exp_sh0    = mul_src_i.exp_sh0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // alignment, sticky and exponent
  ////////////////////////////////////////////////////////////////////////////

  logic                   carry;     // integer part overflowed to bit 27
  fp32_rnd_pkg::shamt_t   shr_eff;
  logic                   do_shr;
  fp32_rnd_pkg::fract28_t fract_sh;
  logic [fp32_rnd_pkg::SHIFT_W:0] lost_cnt; // bits below guard, shr + r + s
  fp32_rnd_pkg::fract28_t keep_mask;
  logic                   sticky_r;
  logic                   sticky_l;

  assign carry   = sel_fract[fp32_rnd_pkg::FRACT_W-1];
  assign shr_eff = (|sel_shr) ? sel_shr : {{(fp32_rnd_pkg::SHIFT_W-1){1'b0}}, carry};
  assign do_shr  = |shr_eff;

  assign fract_sh = do_shr ? (sel_fract >> shr_eff) : (sel_fract << sel_shl);

  // everything that falls below the round bit on a right shift
  assign lost_cnt  = {1'b0, shr_eff} + 6'd2;
  assign keep_mask = {fp32_rnd_pkg::FRACT_W{1'b1}} << lost_cnt; // zero once past width
  assign sticky_r  = |(sel_fract & ~keep_mask);
  // left shift only brings in zeros
  assign sticky_l  = |fract_sh[RND_POS-1:0];

  always_comb begin
    stage_d         = src_d;
    stage_d.mant    = fract_sh[fp32_rnd_pkg::FRACT_W-1 -: fp32_rnd_pkg::MANT_W];
    stage_d.rnd_bit = fract_sh[RND_POS];
    stage_d.sticky  = do_shr ? sticky_r : sticky_l;
    if (|sel_shr) begin
      stage_d.exp = sel_exp_shr;
    end else if (carry | ~(|sel_shl)) begin
      stage_d.exp = sel_exp_sh0 + fp32_rnd_pkg::exp10_t'(carry); // carry shift bumps exp
    end else begin
      stage_d.exp = sel_exp_shl;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv) begin
      stage_o <= stage_d;
    end
  end

  // new take wins over drain in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else if (pipeline_flush_i) begin
      valid_o <= 1'b0;
    end else if (adv) begin
      valid_o <= 1'b1;
    end else if (wb_take_i) begin
      valid_o <= 1'b0;
    end
  end

endmodule

// ==== hdl/fp32_rnd_round.sv ====
// round stage of the fp32 rounding unit, combinational rounding, special values and raw flags
`timescale 1ns/1ps

module fp32_rnd_round (
  input  fp32_rnd_pkg::align_stage_t stage_i,
  input  fp32_rnd_pkg::rnd_mode_t    rmode_i,
  output fp32_rnd_pkg::fp32_t        result_o,
  output fp32_rnd_pkg::fpcsr_flags_t flags_o
);

  ////////////////////////////////////////////////////////////////////////////
  // rounding decision
  ////////////////////////////////////////////////////////////////////////////

  logic g;     // lsb of kept mantissa
  logic r;
  logic s;
  logic lost;  // inexact
  logic rnd_up;

  assign g    = stage_i.mant[0];
  assign r    = stage_i.rnd_bit;
  assign s    = stage_i.sticky;
  assign lost = r | s;

  always_comb begin
    case (rmode_i)
      fp32_rnd_pkg::RM_NEAREST: rnd_up = (r & s) | (g & r & ~s); // ties to even
      fp32_rnd_pkg::RM_TO_INFP: rnd_up = ~stage_i.sign & lost;
      fp32_rnd_pkg::RM_TO_INFM: rnd_up = stage_i.sign & lost;
      default:                  rnd_up = 1'b0;                   // truncate
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // increment and renormalize
  ////////////////////////////////////////////////////////////////////////////

  fp32_rnd_pkg::mant25_t             mant_rnd;
  logic                              mant_carry;
  fp32_rnd_pkg::exp10_t              exp_rnd;
  logic [fp32_rnd_pkg::MANT_W-2:0]   fract24;   // hidden bit + 23
  logic                              denorm;    // hidden bit clear
  logic                              exp_ovf;

  assign mant_rnd   = stage_i.mant + fp32_rnd_pkg::mant25_t'(rnd_up);
  assign mant_carry = mant_rnd[fp32_rnd_pkg::MANT_W-1];
  assign exp_rnd    = stage_i.exp + fp32_rnd_pkg::exp10_t'(mant_carry);
  assign fract24    = mant_carry ? mant_rnd[fp32_rnd_pkg::MANT_W-1:1]
                                 : mant_rnd[fp32_rnd_pkg::MANT_W-2:0];
  assign denorm     = ~fract24[fp32_rnd_pkg::MANT_W-2];
  assign exp_ovf    = exp_rnd > fp32_rnd_pkg::exp10_t'(fp32_rnd_pkg::EXP_MAX_NORMAL);

  ////////////////////////////////////////////////////////////////////////////
  // result select and raw flags
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    flags_o      = '0;
    // operand class flags pass regardless of result kind
    flags_o.inv  = stage_i.inv;
    flags_o.snan = stage_i.snan;
    flags_o.qnan = stage_i.snan | stage_i.qnan;

    if (stage_i.snan | stage_i.qnan) begin
      result_o = {stage_i.nan_sign, fp32_rnd_pkg::FP32_QNAN};
    end else if (stage_i.inv) begin
      result_o = {stage_i.sign, fp32_rnd_pkg::FP32_SNAN};
    end else if (exp_ovf | stage_i.inf) begin
      result_o    = {stage_i.sign, fp32_rnd_pkg::FP32_INF};
      flags_o.inf = 1'b1;
      flags_o.ovf = ~stage_i.inf;          // exact inf operand is not overflow
      flags_o.ine = lost | ~stage_i.inf;
    end else if (denorm) begin
      // exponent field zero, covers true zero too
      result_o    = {stage_i.sign, 8'd0, fract24[22:0]};
      flags_o.ine = lost;
      flags_o.unf = lost;                  // tiny and inexact
      flags_o.zer = ~(|fract24);
    end else begin
      result_o    = {stage_i.sign, exp_rnd[7:0], fract24[22:0]};
      flags_o.ine = lost;
    end
  end

endmodule

// ==== hdl/fp32_rnd_wb.sv ====
// write-back latches of the fp32 rounding unit, masked flags, exception and fpcsr update pulse
`timescale 1ns/1ps

module fp32_rnd_wb (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       pipeline_flush_i,
  input  logic                       padv_wb_i,
  input  logic                       grant_wb_i,
  input  logic                       except_enable_i,
  input  fp32_rnd_pkg::fpcsr_flags_t flag_mask_i,
  input  fp32_rnd_pkg::fp32_t        result_i,
  input  fp32_rnd_pkg::fpcsr_flags_t flags_i,
  output fp32_rnd_pkg::fp32_t        wb_res_o,
  output fp32_rnd_pkg::fpcsr_flags_t wb_flags_o,
  output logic                       wb_except_o,
  output logic                       wb_fpcsr_we_o
);

  fp32_rnd_pkg::fpcsr_flags_t flags_masked;
  logic                       except_d;

  // no grant means nothing of ours reaches wb
  assign flags_masked = flags_i & flag_mask_i & {fp32_rnd_pkg::NFLAGS{grant_wb_i}};
  assign except_d     = except_enable_i & (|flags_masked);

  // result survives a flush
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_res_o <= '0;
    end else if (padv_wb_i) begin
      wb_res_o <= result_i & {32{grant_wb_i}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst | pipeline_flush_i) begin
      wb_flags_o  <= '0;
      wb_except_o <= 1'b0;
    end else if (padv_wb_i) begin
      wb_flags_o  <= flags_masked;
      wb_except_o <= except_d;
    end
  end

  // single cycle so fpcsr is written once per item
  always_ff @(posedge clk) begin
    if (rst | pipeline_flush_i) begin
      wb_fpcsr_we_o <= 1'b0;
    end else begin
      wb_fpcsr_we_o <= padv_wb_i & grant_wb_i;
    end
  end

endmodule

// ==== hdl/fp32_rnd_top.sv ====
// top level of the fp32 rounding unit, align and round stages feeding the write-back latch
`timescale 1ns/1ps

module fp32_rnd_top (
  input  logic                       clk,
  input  logic                       rst,
  // exec unit side
  input  logic                       add_rdy_i,
  input  fp32_rnd_pkg::add_src_t     add_src_i,
  input  logic                       mul_rdy_i,
  input  fp32_rnd_pkg::mul_src_t     mul_src_i,
  output logic                       add_taking_o,
  output logic                       mul_taking_o,
  // config and pipe control
  input  fp32_rnd_pkg::rnd_mode_t    rmode_i,
  input  logic                       pipeline_flush_i,
  input  logic                       padv_wb_i,
  input  logic                       grant_wb_i,
  input  logic                       except_enable_i,
  input  fp32_rnd_pkg::fpcsr_flags_t flag_mask_i,
  // wb side
  output logic                       arith_valid_o,
  output fp32_rnd_pkg::fp32_t        wb_res_o,
  output fp32_rnd_pkg::fpcsr_flags_t wb_flags_o,
  output logic                       wb_except_o,
  output logic                       wb_fpcsr_we_o
);

  logic                       wb_take;
  fp32_rnd_pkg::align_stage_t stage;
  fp32_rnd_pkg::fp32_t        result;
  fp32_rnd_pkg::fpcsr_flags_t flags;

  assign wb_take = padv_wb_i & grant_wb_i; // item consumed by wb

  fp32_rnd_align fp32_rnd_align_inst (
    .clk              (clk),
    .rst              (rst),
    .pipeline_flush_i (pipeline_flush_i),
    .add_rdy_i        (add_rdy_i),
    .mul_rdy_i        (mul_rdy_i),
    .add_src_i        (add_src_i),
    .mul_src_i        (mul_src_i),
    .rmode_i          (rmode_i),
    .wb_take_i        (wb_take),
    .add_taking_o     (add_taking_o),
    .mul_taking_o     (mul_taking_o),
    .valid_o          (arith_valid_o),
    .stage_o          (stage)
  );

  fp32_rnd_round fp32_rnd_round_inst (
    .stage_i  (stage),
    .rmode_i  (rmode_i),
    .result_o (result),
    .flags_o  (flags)
  );

  fp32_rnd_wb fp32_rnd_wb_inst (
    .clk              (clk),
    .rst              (rst),
    .pipeline_flush_i (pipeline_flush_i),
    .padv_wb_i        (padv_wb_i),
    .grant_wb_i       (grant_wb_i),
    .except_enable_i  (except_enable_i),
    .flag_mask_i      (flag_mask_i),
    .result_i         (result),
    .flags_i          (flags),
    .wb_res_o         (wb_res_o),
    .wb_flags_o       (wb_flags_o),
    .wb_except_o      (wb_except_o),
    .wb_fpcsr_we_o    (wb_fpcsr_we_o)
  );

endmodule

// ==== verif/fp32_rnd_ref.svh ====
// reference model of the fp32 rounding unit, included by the testbench to build expected results
`ifndef FP32_RND_REF_SVH
`define FP32_RND_REF_SVH

// align one source per the exec unit contract
function automatic fp32_rnd_pkg::align_stage_t align_ref(
  input logic                    is_add,
  input fp32_rnd_pkg::add_src_t  a,
  input fp32_rnd_pkg::mul_src_t  m,
  input fp32_rnd_pkg::rnd_mode_t mode
);
  fp32_rnd_pkg::align_stage_t st;
  logic [27:0] f;
  int unsigned shr;
  int unsigned shl;
  logic [9:0]  e_shr;
  logic [9:0]  e_shl;
  logic [9:0]  e_sh0;
  logic [63:0] ext; // fraction on top, room below for lost bits
  st = '0;
  if (is_add) begin
    st.sign = a.sub_zero ? (mode == fp32_rnd_pkg::RM_TO_INFM) : a.sign;
    {st.inv, st.inf, st.snan, st.qnan, st.nan_sign} = {a.inv, a.inf, a.snan, a.qnan, a.nan_sign};
    f     = a.fract;
    shr   = 0;
    shl   = 32'(a.shl);
    e_shr = a.exp_sh0;
    e_shl = a.exp_shl;
    e_sh0 = a.exp_sh0;
  end else begin
    st.sign = m.sign;
    {st.inv, st.inf, st.snan, st.qnan, st.nan_sign} = {m.inv, m.inf, m.snan, m.qnan, m.nan_sign};
    f     = m.fract;
    shr   = 32'(m.shr);
    shl   = 32'(m.shl);
    e_shr = m.exp_shr;
    e_shl = m.exp_shl;
    e_sh0 = m.exp_sh0;
  end
  if (shr != 0) begin
    ext    = {f, 36'd0} >> shr;
    st.exp = e_shr;
  end else if (f[27]) begin
    ext    = {f, 36'd0} >> 1; // integer carry, one step right
    st.exp = e_sh0 + 10'd1;
  end else begin
    ext    = {f << shl, 36'd0};
    st.exp = (shl == 0) ? e_sh0 : e_shl;
  end
  st.mant    = ext[63:39];
  st.rnd_bit = ext[38];
  st.sticky  = |ext[37:0];
  return st;
endfunction

// rounded, renormalized {exp, hidden + fraction} and whether bits were lost
function automatic logic [34:0] renorm_ref(
  input fp32_rnd_pkg::align_stage_t st,
  input fp32_rnd_pkg::rnd_mode_t    mode
);
  logic        lost;
  logic        up;
  logic [25:0] m;
  logic [9:0]  e;
  logic [23:0] frac;
  lost = st.rnd_bit | st.sticky;
  case (mode)
    fp32_rnd_pkg::RM_NEAREST: up = st.rnd_bit & (st.sticky | st.mant[0]);
    fp32_rnd_pkg::RM_TO_INFP: up = lost & !st.sign;
    fp32_rnd_pkg::RM_TO_INFM: up = lost & st.sign;
    default:                  up = 1'b0;
  endcase
  m = {1'b0, st.mant} + 26'(up);
  e = st.exp;
  if (m[24]) begin
    frac = m[24:1];
    e    = e + 10'd1;
  end else begin
    frac = m[23:0];
  end
  return {lost, e, frac};
endfunction

function automatic fp32_rnd_pkg::fp32_t round_ref(
  input fp32_rnd_pkg::align_stage_t st,
  input fp32_rnd_pkg::rnd_mode_t    mode
);
  logic [34:0] rn;
  rn = renorm_ref(st, mode);
  if (st.snan | st.qnan) return {st.nan_sign, fp32_rnd_pkg::FP32_QNAN};
  if (st.inv) return {st.sign, fp32_rnd_pkg::FP32_SNAN};
  if (st.inf || rn[33:24] > 10'(fp32_rnd_pkg::EXP_MAX_NORMAL)) begin
    return {st.sign, fp32_rnd_pkg::FP32_INF};
  end
  if (!rn[23]) return {st.sign, 8'h00, rn[22:0]}; // denormal or zero
  return {st.sign, rn[31:24], rn[22:0]};
endfunction

function automatic fp32_rnd_pkg::fpcsr_flags_t flags_ref(
  input fp32_rnd_pkg::align_stage_t st,
  input fp32_rnd_pkg::rnd_mode_t    mode
);
  fp32_rnd_pkg::fpcsr_flags_t fl;
  logic [34:0] rn;
  rn      = renorm_ref(st, mode);
  fl      = '0;
  fl.inv  = st.inv;
  fl.snan = st.snan;
  fl.qnan = st.snan | st.qnan;
  if (st.snan | st.qnan | st.inv) return fl;
  if (st.inf || rn[33:24] > 10'(fp32_rnd_pkg::EXP_MAX_NORMAL)) begin
    fl.inf = 1'b1;
    fl.ovf = !st.inf;
    fl.ine = rn[34] | !st.inf;
  end else if (!rn[23]) begin
    fl.ine = rn[34];
    fl.unf = rn[34];
    fl.zer = (rn[23:0] == 24'd0);
  end else begin
    fl.ine = rn[34];
  end
  return fl;
endfunction

`endif

// ==== verif/fp32_rnd_tb.sv ====
// testbench for the fp32 rounding unit, random and directed items checked against the reference
`timescale 1ns/1ps

module fp32_rnd_tb;

  `include "fp32_rnd_ref.svh"

  localparam int TIMEOUT = 200; // cycles per wait

  typedef struct packed {
    fp32_rnd_pkg::fp32_t        res;
    fp32_rnd_pkg::fpcsr_flags_t flags; // already masked
    logic                       except;
    logic [3:0]                 hold;  // advances without grant first
    logic                       flush; // flush instead of write-back
  } exp_item_t;

  logic clk;
  logic rst;
  logic add_rdy_i;
  logic mul_rdy_i;
  logic pipeline_flush_i;
  logic padv_wb_i;
  logic grant_wb_i;
  logic except_enable_i;
  logic add_taking_o;
  logic mul_taking_o;
  logic arith_valid_o;
  logic wb_except_o;
  logic wb_fpcsr_we_o;
  fp32_rnd_pkg::add_src_t     add_src_i;
  fp32_rnd_pkg::mul_src_t     mul_src_i;
  fp32_rnd_pkg::rnd_mode_t    rmode_i;
  fp32_rnd_pkg::fpcsr_flags_t flag_mask_i;
  fp32_rnd_pkg::fp32_t        wb_res_o;
  fp32_rnd_pkg::fpcsr_flags_t wb_flags_o;

  exp_item_t exp_q[$];
  int        mismatches = 0;
  int        others = 0;
  logic      aborted = 1'b0;
  logic      stim_done = 1'b0;

  fp32_rnd_top fp32_rnd_top_inst (.*);

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_res(input string name, input fp32_rnd_pkg::fp32_t got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input fp32_rnd_pkg::fpcsr_flags_t got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    others++;
    aborted = 1'b1;
    $display("timeout while waiting for %s", what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare process, owns padv, grant and flush
  ////////////////////////////////////////////////////////////////////////////

  initial begin : compare_proc
    exp_item_t           it;
    fp32_rnd_pkg::fp32_t last_res;
    int                  cnt;
    padv_wb_i        = 1'b0;
    grant_wb_i       = 1'b0;
    pipeline_flush_i = 1'b0;
    last_res         = '0;
    while (!aborted) begin
      cnt = 0;
      while (exp_q.size() == 0 && !stim_done && cnt < TIMEOUT) begin
        @(negedge clk);
        if (!rst) cnt++; // idle time during reset is free
      end
      if (exp_q.size() == 0) begin
        if (!stim_done) report_timeout("a new item from the stimulus");
        break;
      end
      it  = exp_q[0];
      cnt = 0;
      while (!arith_valid_o && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
      end
      if (!arith_valid_o) begin
        report_timeout("arith_valid_o");
        break;
      end
      if (it.flush) begin
        @(posedge clk) pipeline_flush_i <= 1'b1;
        @(posedge clk) pipeline_flush_i <= 1'b0;
        @(negedge clk);
        check_bit("arith_valid_o", arith_valid_o, 1'b0);
        check_flags("wb_flags_o", wb_flags_o, '0);
        check_bit("wb_except_o", wb_except_o, 1'b0);
        check_bit("wb_fpcsr_we_o", wb_fpcsr_we_o, 1'b0);
        check_res("wb_res_o", wb_res_o, last_res); // result latch keeps its value
      end else begin
        @(posedge clk);
        padv_wb_i  <= 1'b1;
        grant_wb_i <= (it.hold == 4'd0);
        for (int i = 0; i < int'(it.hold); i++) begin
          @(posedge clk);
          if (i == int'(it.hold) - 1) grant_wb_i <= 1'b1;
          @(negedge clk);
          check_res("wb_res_o", wb_res_o, '0);
          check_flags("wb_flags_o", wb_flags_o, '0);
          check_bit("wb_fpcsr_we_o", wb_fpcsr_we_o, 1'b0);
          check_bit("arith_valid_o", arith_valid_o, 1'b1);
        end
        @(posedge clk);
        padv_wb_i  <= 1'b0;
        grant_wb_i <= 1'b0;
        @(negedge clk);
        check_res("wb_res_o", wb_res_o, it.res);
        check_flags("wb_flags_o", wb_flags_o, it.flags);
        check_bit("wb_except_o", wb_except_o, it.except);
        check_bit("wb_fpcsr_we_o", wb_fpcsr_we_o, 1'b1);
        @(negedge clk);
        check_bit("wb_fpcsr_we_o", wb_fpcsr_we_o, 1'b0); // one cycle only
        last_res = it.res;
      end
      void'(exp_q.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic queue_expected(input logic is_add, input fp32_rnd_pkg::add_src_t a,
                                input fp32_rnd_pkg::mul_src_t m, input logic [3:0] hold,
                                input logic flush);
    fp32_rnd_pkg::align_stage_t st;
    exp_item_t                  it;
    st        = align_ref(is_add, a, m, rmode_i);
    it.res    = round_ref(st, rmode_i);
    it.flags  = flags_ref(st, rmode_i) & flag_mask_i;
    it.except = except_enable_i & (|it.flags);
    it.hold   = hold;
    it.flush  = flush;
    exp_q.push_back(it);
  endtask

  task automatic send_item(input logic is_add, input fp32_rnd_pkg::add_src_t a,
                           input fp32_rnd_pkg::mul_src_t m, input logic [3:0] hold,
                           input logic flush);
    int cnt;
    if (aborted) return;
    @(posedge clk);
    add_rdy_i <= is_add;
    mul_rdy_i <= ~is_add;
    add_src_i <= a;
    mul_src_i <= m;
    cnt = 0;
    @(negedge clk);
    while (!(is_add ? add_taking_o : mul_taking_o) && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    @(posedge clk); // take happens on this edge
    add_rdy_i <= 1'b0;
    mul_rdy_i <= 1'b0;
    if (cnt >= TIMEOUT) report_timeout("add_taking_o or mul_taking_o");
    else queue_expected(is_add, a, m, hold, flush);
  endtask

  task automatic wait_drained();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && !aborted && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0 && !aborted) report_timeout("the write-back of queued items");
  endtask

  // normal product, sometimes with right shift, carry or one left step
  function automatic fp32_rnd_pkg::mul_src_t rand_mul();
    fp32_rnd_pkg::mul_src_t m;
    m         = '0;
    m.sign    = 1'($urandom);
    m.fract   = {2'b01, 26'($urandom)};
    m.exp_sh0 = 10'(1 + $urandom % 250);
    m.exp_shl = m.exp_sh0 - 10'd1;
    case ($urandom % 4)
      1: m.shr = 5'(1 + $urandom % 8);  // denormal, exp_shr stays 0
      2: m.fract[27] = 1'b1;
      3: begin
        m.fract[26:25] = 2'b01;
        m.shl          = 1'b1;
      end
      default: ;
    endcase
    return m;
  endfunction

  task automatic backpressure_test(input fp32_rnd_pkg::mul_src_t m,
                                   input fp32_rnd_pkg::add_src_t a);
    int cnt;
    int held;
    send_item(1'b0, '0, m, 4'd6, 1'b0);
    if (aborted) return;
    add_rdy_i <= 1'b1;
    add_src_i <= a;
    cnt  = 0;
    held = 0;
    @(negedge clk);
    while (!add_taking_o && cnt < TIMEOUT) begin
      if (arith_valid_o) held++;
      @(negedge clk);
      cnt++;
    end
    check_bit("padv_wb_i & grant_wb_i at take", padv_wb_i & grant_wb_i, 1'b1);
    if (held < 5) begin
      others++;
      $display("add_taking_o rose while grant was still withheld");
    end
    @(posedge clk);
    add_rdy_i <= 1'b0;
    if (cnt >= TIMEOUT) report_timeout("add_taking_o after back-pressure");
    else queue_expected(1'b1, a, '0, 4'd0, 1'b0);
    wait_drained();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    fp32_rnd_pkg::add_src_t a;
    fp32_rnd_pkg::mul_src_t m;
    void'($urandom(32'h6935_23f3));
    clk             = 1'b0;
    rst             = 1'b1;
    add_rdy_i       = 1'b0;
    mul_rdy_i       = 1'b0;
    add_src_i       = '0;
    mul_src_i       = '0;
    rmode_i         = fp32_rnd_pkg::RM_NEAREST;
    flag_mask_i     = '1;
    except_enable_i = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // random products in every mode, plus a carry on round-up
    for (int k = 0; k < 4; k++) begin
      @(posedge clk) rmode_i <= fp32_rnd_pkg::rnd_mode_t'(k[1:0]);
      for (int n = 0; n < 40; n++) begin
        send_item(1'b0, '0, rand_mul(), 4'd0, 1'b0);
        wait_drained();
      end
      m         = '0;
      m.fract   = {2'b01, 23'h7F_FFFF, 3'b111};
      m.exp_sh0 = 10'd100;
      send_item(1'b0, '0, m, 4'd0, 1'b0);
      wait_drained();
      // adds: left shift, no shift, carry, zero difference
      a         = '0;
      a.sign    = 1'($urandom);
      a.fract   = {5'b00001, 23'($urandom)};
      a.shl     = 5'd3;
      a.exp_shl = 10'd60;
      a.exp_sh0 = 10'd63;
      send_item(1'b1, a, '0, 4'd0, 1'b0);
      wait_drained();
      a.shl   = 5'd0;
      a.fract = {2'b01, 26'($urandom)};
      send_item(1'b1, a, '0, 4'd0, 1'b0);
      wait_drained();
      a.fract = {2'b11, 26'($urandom)};
      send_item(1'b1, a, '0, 4'd0, 1'b0);
      wait_drained();
      a          = '0;
      a.sign     = 1'b1;
      a.sub_zero = 1'b1;
      send_item(1'b1, a, '0, 4'd0, 1'b0);
      wait_drained();
    end

    // overflow, lossy denormal, zero
    @(posedge clk) rmode_i <= fp32_rnd_pkg::RM_NEAREST;
    m         = '0;
    m.fract   = {2'b01, 26'h155_5555};
    m.exp_sh0 = 10'd300;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    m.shr = 5'd4;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    send_item(1'b1, '0, '0, 4'd0, 1'b0);
    wait_drained();

    // special operands
    m          = '0;
    m.nan_sign = 1'b1;
    m.qnan     = 1'b1;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    m.snan = 1'b1;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    m     = '0;
    m.inv = 1'b1;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    m     = '0;
    m.inf = 1'b1;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();

    // masking, exceptions, advance without grant
    m         = '0;
    m.fract   = {2'b01, 26'h000_0007};
    m.exp_sh0 = 10'd400;
    @(posedge clk);
    flag_mask_i     <= 8'hF0; // ovf, unf and the nan flags hidden
    except_enable_i <= 1'b1;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    m.exp_sh0 = 10'd20;
    send_item(1'b0, '0, m, 4'd3, 1'b0);
    wait_drained();
    m.qnan = 1'b1; // qnan flag masked off so no exception
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    m.qnan = 1'b0;

    backpressure_test(rand_mul(), a);

    // flush after an item that leaves flags and exception set
    m.exp_sh0 = 10'd500;
    send_item(1'b0, '0, m, 4'd0, 1'b0);
    wait_drained();
    send_item(1'b0, '0, rand_mul(), 4'd0, 1'b1);
    wait_drained();

    stim_done = 1'b1;
    repeat (3) @(posedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatches, others);
    if (mismatches == 0 && others == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verif
common/fp32_rnd_pkg.sv
hdl/fp32_rnd_align.sv
hdl/fp32_rnd_round.sv
hdl/fp32_rnd_wb.sv
hdl/fp32_rnd_top.sv
verif/fp32_rnd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module fp32_rnd_tb -f flist.f \
  -o sim_fp32_rnd > build.log 2>&1 \
  || { cat build.log; exit 1; }

./obj_dir/sim_fp32_rnd > sim.log 2>&1 || { cat sim.log; exit 1; }

cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
